// File: verilog.f
mulPkg.sv
recipTable.sv
mulOpDecode.sv
mulPipeline.sv
mulDivTop.sv
mulDivTop_sva.sv
mulDivTop_tb.sv

// File: mulDivTop_tb.sv
// table-driven testbench for the multiply and fast divide unit
// rows are applied one per rising edge, results are matched three counted edges later
`timescale 1ns/1ps
`default_nettype none

module mulDivTop_tb;
	import mulPkg::*;

	localparam int clockPeriod = 100;

	typedef struct {
		string name;
		mulOp_t opKind;
		logic signedOp;
		logic [operandWidth-1:0] srcA;
		logic [operandWidth-1:0] srcB;
		logic [resultWidth-1:0] accIn;
		logic hold;
		logic [resultWidth-1:0] expResult;
		logic expFastDiv;
	} stimRow_t;

	logic clock = 1'b0;
	logic rstN;
	logic hold;
	mulOp_t opKind;
	logic signedOp;
	logic [operandWidth-1:0] srcA;
	logic [operandWidth-1:0] srcB;
	logic [resultWidth-1:0] accIn;
	logic [resultWidth-1:0] result;
	logic fastDiv;
	logic fastDivDone;

	stimRow_t rows[$];
	// row indices issued into the pipe where -1 marks an idle slot
	int pipeQ[$];
	int curIdx = -1;
	int outIdx = -1;
	logic tableReady = 1'b0;
	logic [31:0] rngState = 32'hea0c_1861;

	mulDivTop #(
		.fastDivEnable(1'b1)
	) dut0 (
		.clock(clock),
		.rstN(rstN),
		.hold(hold),
		.opKind(opKind),
		.signedOp(signedOp),
		.srcA(srcA),
		.srcB(srcB),
		.accIn(accIn),
		.result(result),
		.fastDiv(fastDiv),
		.fastDivDone(fastDivDone)
	);

	always #(clockPeriod / 2) clock = ~clock;

	function automatic logic [31:0] nextRandom();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	function automatic logic fastExpected(mulOp_t op, logic [31:0] a, logic [31:0] b);
		return (op == opDiv) && (b >= 2) && (b <= fastDivMaxDivisor)
			&& (a < (32'd1 << fastDivDividendBits));
	endfunction

	// reference result straight from the operation rules
	function automatic logic [63:0] expectedResult(mulOp_t op, logic sgn, logic [31:0] a,
			logic [31:0] b, logic [63:0] acc);
		logic [63:0] extA;
		logic [63:0] extB;
		logic [63:0] prod;
		extA = sgn ? {{32{a[31]}}, a} : {32'd0, a};
		extB = sgn ? {{32{b[31]}}, b} : {32'd0, b};
		prod = extA * extB;
		case (op)
			opMulLo: return {{32{sgn & prod[31]}}, prod[31:0]};
			opMulWide: return prod;
			opMac: return prod + acc;
			default: return fastExpected(op, a, b) ? {32'd0, a / b} : 64'd0;
		endcase
	endfunction

	task automatic addRow(input string name, input mulOp_t op, input logic sgn,
			input logic [31:0] a, input logic [31:0] b, input logic [63:0] acc,
			input logic holdFlag);
		stimRow_t r;
		r.name = name;
		r.opKind = op;
		r.signedOp = sgn;
		r.srcA = a;
		r.srcB = b;
		r.accIn = acc;
		r.hold = holdFlag;
		r.expResult = expectedResult(op, sgn, a, b, acc);
		r.expFastDiv = fastExpected(op, a, b);
		rows.push_back(r);
	endtask

	task automatic buildTable();
		addRow("lo signed neg", opMulLo, 1'b1, 32'hffff_fffd, 32'd7, 64'd0, 1'b0);
		addRow("lo unsigned neg", opMulLo, 1'b0, 32'hffff_fffd, 32'd7, 64'd0, 1'b0);
		addRow("lo signed wrap", opMulLo, 1'b1, 32'h0001_0000, 32'h0000_8000, 64'd0, 1'b0);
		addRow("lo acc ignored", opMulLo, 1'b1, 32'h8000_0001, 32'hffff_ffff, 64'h1234, 1'b0);
		addRow("wide signed min", opMulWide, 1'b1, 32'h8000_0000, 32'h8000_0000, 64'd0, 1'b0);
		addRow("wide signed mixed", opMulWide, 1'b1, 32'h8000_0000, 32'h7fff_ffff, 64'hdead,
			1'b0);
		addRow("wide unsigned max", opMulWide, 1'b0, '1, '1, 64'd0, 1'b0);
		addRow("mac signed", opMac, 1'b1, 32'hffff_fffb, 32'd9, 64'd100, 1'b0);
		addRow("mac wrap", opMac, 1'b0, '1, '1, '1, 1'b0);
		// operands that would qualify for the fast path if the op were a divide
		addRow("wide small operands", opMulWide, 1'b0, 32'd1000, 32'd7, 64'd0, 1'b0);
		addRow("mac small operands", opMac, 1'b1, 32'd1000, 32'd7, 64'd5, 1'b0);
		addRow("div by zero", opDiv, 1'b0, 32'd1000, 32'd0, 64'd0, 1'b0);
		addRow("div by one", opDiv, 1'b0, 32'd1000, 32'd1, 64'd0, 1'b0);
		addRow("div by 64", opDiv, 1'b0, 32'd1000, 32'd64, 64'd0, 1'b0);
		addRow("div by big", opDiv, 1'b1, 32'd1000, 32'h0001_0003, 64'd0, 1'b0);
		addRow("div big dividend", opDiv, 1'b0, 32'h4000_0000, 32'd7, 64'd0, 1'b0);
		addRow("div top dividend", opDiv, 1'b1, 32'hffff_ffff, 32'd3, 64'd0, 1'b0);
		addRow("div max fast", opDiv, 1'b0, 32'h3fff_ffff, 32'd63, 64'd0, 1'b0);
		for (int d = 2; d <= fastDivMaxDivisor; d++) begin
			addRow($sformatf("div by %0d", d), opDiv, 1'b0, nextRandom() & 32'h3fff_ffff, d,
				{nextRandom(), nextRandom()}, 1'b0);
		end
		for (int k = 0; k < 8; k++) begin
			addRow($sformatf("wide signed %0d", k), opMulWide, 1'b1, nextRandom(),
				nextRandom(), 64'd0, 1'b0);
			addRow($sformatf("wide unsigned %0d", k), opMulWide, 1'b0, nextRandom(),
				nextRandom(), 64'd0, 1'b0);
			addRow($sformatf("mac %0d", k), opMac, k[0], nextRandom(), nextRandom(),
				{nextRandom(), nextRandom()}, 1'b0);
			addRow($sformatf("lo %0d", k), opMulLo, k[1], nextRandom(), nextRandom(),
				{nextRandom(), nextRandom()}, 1'b0);
		end
		// three in flight and then a hold while the inputs keep changing
		addRow("burst mac", opMac, 1'b1, nextRandom(), nextRandom(), 64'd77, 1'b0);
		addRow("burst div", opDiv, 1'b0, 32'd1000, 32'd7, 64'd0, 1'b0);
		addRow("burst wide", opMulWide, 1'b1, nextRandom(), nextRandom(), 64'd0, 1'b0);
		for (int k = 0; k < 4; k++) begin
			addRow($sformatf("hold %0d", k), opDiv, 1'b0, nextRandom() & 32'h3fff_ffff,
				32'd5, 64'd0, 1'b1);
		end
		addRow("resume lo", opMulLo, 1'b1, nextRandom(), nextRandom(), 64'd0, 1'b0);
		addRow("resume div", opDiv, 1'b0, 32'd123456, 32'd12, 64'd0, 1'b0);
	endtask

	task automatic checkResult(input string name, input logic [resultWidth-1:0] expected,
			input logic [resultWidth-1:0] actual);
		if (actual !== expected) begin
			$display("ERROR %s expected %h actual %h", name, expected, actual);
			$display("TB FAILED");
			$fatal(1);
		end
	endtask

	task automatic checkFlag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("ERROR %s expected %b actual %b", name, expected, actual);
			$display("TB FAILED");
			$fatal(1);
		end
	endtask

	// track the pipe and drive the next row on each edge, check mid-cycle
	task automatic stepCycle(input int idx);
		@(posedge clock);
		if (!hold) begin
			pipeQ.push_back(curIdx);
			if (pipeQ.size() == 3)
				outIdx = pipeQ.pop_front();
		end
		if (idx >= 0) begin
			hold <= rows[idx].hold;
			opKind <= rows[idx].opKind;
			signedOp <= rows[idx].signedOp;
			srcA <= rows[idx].srcA;
			srcB <= rows[idx].srcB;
			accIn <= rows[idx].accIn;
		end else begin
			hold <= 1'b0;
			opKind <= opMulLo;
			signedOp <= 1'b0;
			srcA <= '0;
			srcB <= '0;
			accIn <= '0;
		end
		curIdx = idx;
		@(negedge clock);
		if (curIdx >= 0)
			checkFlag({rows[curIdx].name, " fastDiv"}, rows[curIdx].expFastDiv, fastDiv);
		else
			checkFlag("idle fastDiv", 1'b0, fastDiv);
		if (outIdx >= 0) begin
			checkResult(rows[outIdx].name, rows[outIdx].expResult, result);
			checkFlag({rows[outIdx].name, " done"}, rows[outIdx].expFastDiv, fastDivDone);
		end else begin
			checkResult("idle", '0, result);
			checkFlag("idle done", 1'b0, fastDivDone);
		end
	endtask

	initial begin
		rstN = 1'b0;
		hold = 1'b0;
		opKind = opMulLo;
		signedOp = 1'b0;
		srcA = '0;
		srcB = '0;
		accIn = '0;
		buildTable();
		tableReady = 1'b1;
		repeat (10) @(posedge clock);
		rstN <= 1'b1;
		for (int i = 0; i < rows.size(); i++)
			stepCycle(i);
		// drain the three stages
		repeat (3) stepCycle(-1);
		$display("TB PASSED");
		$finish;
	end

	initial begin : watchdog
		int unsigned limitCycles;
		wait (tableReady);
		limitCycles = rows.size() * 2 + 10 + 20;
		#(limitCycles * clockPeriod);
		$display("run timed out after %0d cycles before the table was finished", limitCycles);
		$display("TB FAILED");
		$fatal(1);
	end

endmodule

`default_nettype wire

// File: mulDivTop_sva.sv
// concurrent checks on the multiply unit outputs
// bound into every mulDivTop instance
`timescale 1ns/1ps
`default_nettype none

module mulDivTop_sva (
	input logic clock,
	input logic rstN,
	input logic hold,
	input mulPkg::mulOp_t opKind,
	input logic [mulPkg::resultWidth-1:0] result,
	input logic fastDiv,
	input logic fastDivDone
);
	import mulPkg::*;

	// a held edge leaves the outputs alone
	holdFreeze: assert property (@(posedge clock) disable iff (!rstN)
		hold |=> ($stable(result) && $stable(fastDivDone)))
		else $error("result or fastDivDone moved while hold was high");

	doneAfterReset: assert property (@(posedge clock) $rose(rstN) |-> !fastDivDone)
		else $error("fastDivDone was high right after reset release");

	fastDivOnDiv: assert property (@(posedge clock) disable iff (!rstN)
		fastDiv |-> (opKind == opDiv))
		else $error("fastDiv raised for an operation other than divide");

endmodule

bind mulDivTop mulDivTop_sva sva0 (
	.clock(clock),
	.rstN(rstN),
	.hold(hold),
	.opKind(opKind),
	.result(result),
	.fastDiv(fastDiv),
	.fastDivDone(fastDivDone)
);

`default_nettype wire

// File: mulDivTop.sv
// top level of the integer multiply and fast divide unit
// operands are taken on every rising edge with hold low, results
// appear three counted edges later, fastDiv answers in the issue cycle
`timescale 1ns/1ps
`default_nettype none

module mulDivTop #(
	parameter bit fastDivEnable = 1'b1
) (
	input  logic clock,
	input  logic rstN,
	input  logic hold,
	input  mulPkg::mulOp_t opKind,
	input  logic signedOp,
	input  logic [mulPkg::operandWidth-1:0] srcA,
	input  logic [mulPkg::operandWidth-1:0] srcB,
	input  logic [mulPkg::resultWidth-1:0] accIn,
	output logic [mulPkg::resultWidth-1:0] result,
	output logic fastDiv,
	output logic fastDivDone
);
	import mulPkg::*;

	logic [operandWidth-1:0] mulB;
	logic signMode;
	resFmt_t resFmt;
	divShift_t quotShift;
	logic [resultWidth-1:0] accGated;

	mulOpDecode #(
		.fastDivEnable(fastDivEnable)
	) decode0 (
		.opKind(opKind),
		.signedOp(signedOp),
		.srcA(srcA),
		.srcB(srcB),
		.accIn(accIn),
		.mulB(mulB),
		.signMode(signMode),
		.resFmt(resFmt),
		.quotShift(quotShift),
		.accGated(accGated),
		.fastDiv(fastDiv)
	);

	// fastDiv doubles as the quotient valid bit down the pipe
	mulPipeline pipe0 (
		.clock(clock),
		.rstN(rstN),
		.hold(hold),
		.srcA(srcA),
		.mulB(mulB),
		.signMode(signMode),
		.resFmt(resFmt),
		.quotShift(quotShift),
		.quotValid(fastDiv),
		.accGated(accGated),
		.result(result),
		.fastDivDone(fastDivDone)
	);

endmodule

`default_nettype wire

// File: mulPipeline.sv
// three-stage 32x32 multiplier built from four 16x16 partial products
// stage 1 multiplies, stage 2 aligns the cross terms, stage 3 adds the
// accumulator and formats the result; hold freezes every stage
`timescale 1ns/1ps
`default_nettype none

module mulPipeline (
	input  logic clock,
	input  logic rstN,
	input  logic hold,
	input  logic [mulPkg::operandWidth-1:0] srcA,
	input  logic [mulPkg::operandWidth-1:0] mulB,
	input  logic signMode,
	input  mulPkg::resFmt_t resFmt,
	input  mulPkg::divShift_t quotShift,
	input  logic quotValid,
	input  logic [mulPkg::resultWidth-1:0] accGated,
	output logic [mulPkg::resultWidth-1:0] result,
	output logic fastDivDone
);
	import mulPkg::*;

	localparam int halfWidth = operandWidth / 2;
	localparam int crossWidth = operandWidth + 3;
	localparam int crossExt = resultWidth - crossWidth - halfWidth;
	localparam int quotBase = fastDivDividendBits + 1;

	// operand halves with one extension bit each
	logic signed [halfWidth:0] aLo;
	logic signed [halfWidth:0] aHi;
	logic signed [halfWidth:0] bLo;
	logic signed [halfWidth:0] bHi;

	logic [operandWidth-1:0] s1LoLo;
	logic signed [operandWidth+1:0] s1LoHi;
	logic signed [operandWidth+1:0] s1HiLo;
	logic signed [operandWidth+1:0] s1HiHi;
	resFmt_t s1Fmt;
	divShift_t s1Shift;
	logic s1Sign;
	logic s1QuotValid;
	logic [resultWidth-1:0] s1Acc;

	logic signed [crossWidth-1:0] crossSum;
	logic [resultWidth-1:0] s2Base;
	logic [resultWidth-1:0] s2Cross;
	resFmt_t s2Fmt;
	divShift_t s2Shift;
	logic s2Sign;
	logic s2QuotValid;
	logic [resultWidth-1:0] s2Acc;

	logic [resultWidth-1:0] fullSum;
	logic [resultWidth-quotBase-1:0] quotBits;
	logic [resultWidth-1:0] formatted;

	// low halves are always unsigned, high halves extend by sign mode
	assign aLo = {1'b0, srcA[halfWidth-1:0]};
	assign bLo = {1'b0, mulB[halfWidth-1:0]};
	assign aHi = {signMode & srcA[operandWidth-1], srcA[operandWidth-1:halfWidth]};
	assign bHi = {signMode & mulB[operandWidth-1], mulB[operandWidth-1:halfWidth]};

	// stage 1
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			s1LoLo <= '0;
			s1LoHi <= '0;
			s1HiLo <= '0;
			s1HiHi <= '0;
			s1Fmt <= fmtLo;
			s1Shift <= '0;
			s1Sign <= 1'b0;
			s1QuotValid <= 1'b0;
			s1Acc <= '0;
		end else if (!hold) begin
			s1LoLo <= srcA[halfWidth-1:0] * mulB[halfWidth-1:0];
			s1LoHi <= aLo * bHi;
			s1HiLo <= aHi * bLo;
			s1HiHi <= aHi * bHi;
			s1Fmt <= resFmt;
			s1Shift <= quotShift;
			s1Sign <= signMode;
			s1QuotValid <= quotValid;
			s1Acc <= accGated;
		end
	end

	// both cross products land at bit 16, merge them before aligning
	assign crossSum = s1LoHi + s1HiLo;

	// stage 2
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			s2Base <= '0;
			s2Cross <= '0;
			s2Fmt <= fmtLo;
			s2Shift <= '0;
			s2Sign <= 1'b0;
			s2QuotValid <= 1'b0;
			s2Acc <= '0;
		end else if (!hold) begin
			// high-high sits directly above low-low, bits past 64 drop off
			s2Base <= {s1HiHi[operandWidth-1:0], s1LoLo};
			s2Cross <= {{crossExt{crossSum[crossWidth-1]}}, crossSum, {halfWidth{1'b0}}};
			s2Fmt <= s1Fmt;
			s2Shift <= s1Shift;
			s2Sign <= s1Sign;
			s2QuotValid <= s1QuotValid;
			s2Acc <= s1Acc;
		end
	end

	assign fullSum = s2Base + s2Cross + s2Acc;
	assign quotBits = fullSum[resultWidth-1:quotBase] >> s2Shift;

	always_comb begin
		case (s2Fmt)
			fmtLo: formatted = {{(resultWidth - operandWidth){s2Sign & fullSum[operandWidth-1]}},
				fullSum[operandWidth-1:0]};
			fmtWide: formatted = fullSum;
			fmtQuot: formatted = s2QuotValid ? {{quotBase{1'b0}}, quotBits} : '0;
			default: formatted = '0;
		endcase
	end

	// stage 3
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			result <= '0;
			fastDivDone <= 1'b0;
		end else if (!hold) begin
			result <= formatted;
			fastDivDone <= s2QuotValid;
		end
	end

endmodule

`default_nettype wire

// File: mulOpDecode.sv
// operation decode in front of the multiply pipeline
// picks sign mode and result format, swaps in the reciprocal on a
// fast division and gates the accumulator to multiply-accumulate only
`timescale 1ns/1ps
`default_nettype none

module mulOpDecode #(
	parameter bit fastDivEnable = 1'b1
) (
	input  mulPkg::mulOp_t opKind,
	input  logic signedOp,
	input  logic [mulPkg::operandWidth-1:0] srcA,
	input  logic [mulPkg::operandWidth-1:0] srcB,
	input  logic [mulPkg::resultWidth-1:0] accIn,
	output logic [mulPkg::operandWidth-1:0] mulB,
	output logic signMode,
	output mulPkg::resFmt_t resFmt,
	output mulPkg::divShift_t quotShift,
	output logic [mulPkg::resultWidth-1:0] accGated,
	output logic fastDiv
);
	import mulPkg::*;

	logic [operandWidth-1:0] recip;
	logic fastOk;

	recipTable recipTable0 (
		.divisor(srcB),
		.dividend(srcA),
		.recip(recip),
		.quotShift(quotShift),
		.fastOk(fastOk)
	);

	assign fastDiv = fastDivEnable && (opKind == opDiv) && fastOk;

	// reciprocal multiply is always unsigned
	assign mulB = fastDiv ? recip : srcB;
	assign signMode = fastDiv ? 1'b0 : signedOp;

	// a declined division still selects fmtQuot, quotValid low zeroes it
	always_comb begin
		case (opKind)
			opMulLo: resFmt = fmtLo;
			opMulWide: resFmt = fmtWide;
			opMac: resFmt = fmtWide;
			default: resFmt = fmtQuot;
		endcase
	end

	assign accGated = (opKind == opMac) ? accIn : '0;

endmodule

`default_nettype wire

// File: recipTable.sv
// reciprocal lookup for division by a small constant
// divisor is split into odd * 2^k, the quotient is read from the
// high bits of dividend * recip, shifted by quotShift beyond the base
`timescale 1ns/1ps
`default_nettype none

module recipTable (
	input  logic [mulPkg::operandWidth-1:0] divisor,
	input  logic [mulPkg::operandWidth-1:0] dividend,
	output logic [mulPkg::operandWidth-1:0] recip,
	output mulPkg::divShift_t quotShift,
	output logic fastOk
);
	import mulPkg::*;

	localparam int idxBits = $clog2(fastDivMaxDivisor + 1);
	localparam int romDepth = (fastDivMaxDivisor + 1) / 2;
	localparam int entryWidth = 3 + operandWidth;

	typedef logic [entryWidth-1:0] recipRom_t [romDepth];

	// entry i covers odd = 2*i + 1, holding clog2(odd) and the rounded-up
	// 2^(dividendBits + clog2(odd)) / odd
	function automatic recipRom_t buildRecipRom();
		recipRom_t rom;
		longint unsigned odd;
		longint unsigned scale;
		longint unsigned logOdd;
		for (int i = 0; i < romDepth; i++) begin
			odd = 2 * i + 1;
			logOdd = $clog2(odd);
			scale = 64'd1 << (fastDivDividendBits + logOdd);
			rom[i] = {3'(logOdd), operandWidth'((scale + odd - 1) / odd)};
		end
		return rom;
	endfunction

	localparam recipRom_t recipRom = buildRecipRom();

	logic [2:0] twoPow;
	logic [idxBits-1:0] oddPart;
	logic [2:0] oddLog;
	logic [3:0] shiftSum;

	// trailing zeros of the divisor give the power of two
	always_comb begin
		casez (divisor[idxBits-1:0])
			6'b?????1: twoPow = 3'd0;
			6'b????10: twoPow = 3'd1;
			6'b???100: twoPow = 3'd2;
			6'b??1000: twoPow = 3'd3;
			6'b?10000: twoPow = 3'd4;
			6'b100000: twoPow = 3'd5;
			default: twoPow = 3'd0;
		endcase
	end

	assign oddPart = divisor[idxBits-1:0] >> twoPow;
	assign {oddLog, recip} = recipRom[oddPart[idxBits-1:1]];

	// total shift is dividendBits + clog2(odd) + k, base is dividendBits + 1
	assign shiftSum = {1'b0, oddLog} + {1'b0, twoPow} - 4'd1;
	assign quotShift = shiftSum[2:0];

	assign fastOk = (divisor >= 2) && (divisor <= fastDivMaxDivisor)
		&& (dividend[operandWidth-1:fastDivDividendBits] == '0);

endmodule

`default_nettype wire

// File: mulPkg.sv
// shared definitions for the integer multiply and fast divide unit
// every module of the unit and the testbench import from here
`default_nettype none

package mulPkg;

	// datapath widths
	localparam int operandWidth = 32;
	localparam int resultWidth = 64;

	// fast divide coverage
	localparam int fastDivMaxDivisor = 63;
	// dividend must fit in this many bits
	localparam int fastDivDividendBits = 30;

	// operation requested by the issuing stage
	typedef enum logic [1:0] {
		opMulLo = 2'd0,
		opMulWide = 2'd1,
		opMac = 2'd2,
		opDiv = 2'd3
	} mulOp_t;

	// how the final sum is shaped into the result
	// fmtLo fills the upper half with sign or zero
	// fmtWide is the full product plus accumulator
	// fmtQuot takes the quotient from the high product bits
	typedef enum logic [1:0] {
		fmtLo = 2'd0,
		fmtWide = 2'd1,
		fmtQuot = 2'd2
	} resFmt_t;

	// extra right shift of the quotient beyond the fixed base
	typedef logic [2:0] divShift_t;

endpackage

`default_nettype wire
